//--- src/axicb_pkg.sv
//////////////////////////////
// Field widths, response codes and packed channel widths shared by
// the master port stage and its testbench
//////////////////////////////

package axicb_pkg;

    //////////////////////////////
    // AXI4-lite field widths
    //////////////////////////////

    localparam int PROT_W = 3;
    localparam int RESP_W = 2;

    // Response codes
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    //////////////////////////////
    // Packed channel widths
    //////////////////////////////

    // AW and AR word is {prot, id, addr}
    function automatic int awch_width(input int addr_w, input int id_w);
        return PROT_W + id_w + addr_w;
    endfunction

    // W word is {strb, data}, one strobe bit per byte
    function automatic int wch_width(input int data_w);
        return data_w / 8 + data_w;
    endfunction

    // B word is {resp, id}
    function automatic int bch_width(input int id_w);
        return RESP_W + id_w;
    endfunction

    // R word is {data, resp, id}
    function automatic int rch_width(input int data_w, input int id_w);
        return data_w + RESP_W + id_w;
    endfunction

    // FIFO pointer width, depth rounds up to a power of two
    function automatic int fifo_addr_w(input int depth);
        return (depth < 2) ? 1 : $clog2(depth);
    endfunction

endpackage

//--- src/axicb_scfifo.sv
//////////////////////////////
// Single-clock FIFO used to buffer every channel of the port stage
// Push and pull are ignored when full or empty, head entry is always shown
//////////////////////////////

module axicb_scfifo #(
    parameter int ADDR_WIDTH = 2,
    parameter int DATA_WIDTH = 8
) (
    input  logic                  i_aclk,
    input  logic                  i_reset,
    input  logic                  i_push,
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic                  o_full,
    input  logic                  i_pull,
    output logic [DATA_WIDTH-1:0] o_data,
    output logic                  o_empty
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;
    logic                  do_push;
    logic                  do_pull;

    // Qualified requests
    assign do_push = i_push && !o_full;
    assign do_pull = i_pull && !o_empty;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge i_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_data = mem[rd_ptr];

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge i_aclk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their natural width
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Count tops out at DEPTH, so its MSB alone marks full
    assign o_full  = count[ADDR_WIDTH];
    assign o_empty = (count == '0);

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_full_empty_excl: assert property (
        @(posedge i_aclk) disable iff (i_reset)
        !(o_full && o_empty)
    );

    a_count_bound: assert property (
        @(posedge i_aclk) disable iff (i_reset)
        count <= DEPTH
    );

endmodule

//--- src/axicb_req_path.sv
//////////////////////////////
// Request side of the port stage, buffers AW, W and AR toward the slave
// Splits each head word into fields and strips the slave base address
//////////////////////////////

module axicb_req_path #(
    parameter int                    AXI_ADDR_W      = 16,
    parameter int                    AXI_ID_W        = 4,
    parameter int                    AXI_DATA_W      = 32,
    parameter logic [AXI_ADDR_W-1:0] BASE_ADDR       = 16'h4000,
    parameter int                    KEEP_BASE_ADDR  = 0,
    parameter int                    SLV_OSTDREQ_NUM = 4
) (
    input  logic                                                  i_aclk,
    input  logic                                                  i_reset,
    // AW and W from the switching logic
    input  logic                                                  i_awvalid,
    output logic                                                  o_awready,
    input  logic [axicb_pkg::awch_width(AXI_ADDR_W, AXI_ID_W)-1:0] i_awch,
    input  logic                                                  i_wvalid,
    output logic                                                  o_wready,
    input  logic [axicb_pkg::wch_width(AXI_DATA_W)-1:0]           i_wch,
    // AR from the switching logic
    input  logic                                                  i_arvalid,
    output logic                                                  o_arready,
    input  logic [axicb_pkg::awch_width(AXI_ADDR_W, AXI_ID_W)-1:0] i_arch,
    // AW and W to the slave
    output logic                                                  o_awvalid,
    input  logic                                                  i_awready,
    output logic [AXI_ADDR_W-1:0]                                 o_awaddr,
    output logic [axicb_pkg::PROT_W-1:0]                          o_awprot,
    output logic [AXI_ID_W-1:0]                                   o_awid,
    output logic                                                  o_wvalid,
    input  logic                                                  i_wready,
    output logic [AXI_DATA_W-1:0]                                 o_wdata,
    output logic [AXI_DATA_W/8-1:0]                               o_wstrb,
    // AR to the slave
    output logic                                                  o_arvalid,
    input  logic                                                  i_arready,
    output logic [AXI_ADDR_W-1:0]                                 o_araddr,
    output logic [axicb_pkg::PROT_W-1:0]                          o_arprot,
    output logic [AXI_ID_W-1:0]                                   o_arid
);

    import axicb_pkg::*;

    localparam int AWCH_W = awch_width(AXI_ADDR_W, AXI_ID_W);
    localparam int WCH_W  = wch_width(AXI_DATA_W);
    localparam int FIFO_A = fifo_addr_w(SLV_OSTDREQ_NUM);

    logic [AWCH_W-1:0]     awch;
    logic [WCH_W-1:0]      wch;
    logic [AWCH_W-1:0]     arch;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  aw_full;
    logic                  aw_empty;
    logic                  w_full;
    logic                  w_empty;
    logic                  ar_full;
    logic                  ar_empty;

    //////////////////////////////
    // Channel buffers
    //////////////////////////////

    axicb_scfifo #(.ADDR_WIDTH(FIFO_A), .DATA_WIDTH(AWCH_W)) aw_fifo (
        .i_aclk(i_aclk), .i_reset(i_reset),
        .i_push(i_awvalid), .i_data(i_awch), .o_full(aw_full),
        .i_pull(i_awready), .o_data(awch), .o_empty(aw_empty)
    );

    axicb_scfifo #(.ADDR_WIDTH(FIFO_A), .DATA_WIDTH(WCH_W)) w_fifo (
        .i_aclk(i_aclk), .i_reset(i_reset),
        .i_push(i_wvalid), .i_data(i_wch), .o_full(w_full),
        .i_pull(i_wready), .o_data(wch), .o_empty(w_empty)
    );

    axicb_scfifo #(.ADDR_WIDTH(FIFO_A), .DATA_WIDTH(AWCH_W)) ar_fifo (
        .i_aclk(i_aclk), .i_reset(i_reset),
        .i_push(i_arvalid), .i_data(i_arch), .o_full(ar_full),
        .i_pull(i_arready), .o_data(arch), .o_empty(ar_empty)
    );

    assign o_awready = !aw_full;
    assign o_awvalid = !aw_empty;
    assign o_wready  = !w_full;
    assign o_wvalid  = !w_empty;
    assign o_arready = !ar_full;
    assign o_arvalid = !ar_empty;

    // Field split of the head words
    assign {o_awprot, o_awid, awaddr} = awch;
    assign {o_arprot, o_arid, araddr} = arch;
    assign {o_wstrb, o_wdata}         = wch;

    //////////////////////////////
    // Slave address map
    //////////////////////////////

    if (KEEP_BASE_ADDR > 0) begin : g_keep_base
        assign o_awaddr = awaddr;
        assign o_araddr = araddr;
    end else begin : g_strip_base
        assign o_awaddr = awaddr - BASE_ADDR;
        assign o_araddr = araddr - BASE_ADDR;

        // Switch must only route addresses inside this slave's window
        a_aw_in_window: assert property (
            @(posedge i_aclk) disable iff (i_reset)
            o_awvalid |-> (awaddr >= BASE_ADDR)
        );
        a_ar_in_window: assert property (
            @(posedge i_aclk) disable iff (i_reset)
            o_arvalid |-> (araddr >= BASE_ADDR)
        );
    end

endmodule

//--- src/axicb_rsp_path.sv
//////////////////////////////
// Response side of the port stage, packs slave B and R into channel words
//////////////////////////////

module axicb_rsp_path #(
    parameter int AXI_ID_W        = 4,
    parameter int AXI_DATA_W      = 32,
    parameter int SLV_OSTDREQ_NUM = 4
) (
    input  logic                                                 i_aclk,
    input  logic                                                 i_reset,
    // From the slave
    input  logic                                                 i_bvalid,
    output logic                                                 o_bready,
    input  logic [AXI_ID_W-1:0]                                  i_bid,
    input  logic [axicb_pkg::RESP_W-1:0]                         i_bresp,
    input  logic                                                 i_rvalid,
    output logic                                                 o_rready,
    input  logic [AXI_ID_W-1:0]                                  i_rid,
    input  logic [axicb_pkg::RESP_W-1:0]                         i_rresp,
    input  logic [AXI_DATA_W-1:0]                                i_rdata,
    // To the switching logic
    output logic                                                 o_bvalid,
    input  logic                                                 i_bready,
    output logic [axicb_pkg::bch_width(AXI_ID_W)-1:0]            o_bch,
    output logic                                                 o_rvalid,
    input  logic                                                 i_rready,
    output logic [axicb_pkg::rch_width(AXI_DATA_W, AXI_ID_W)-1:0] o_rch
);

    import axicb_pkg::*;

    localparam int BCH_W  = bch_width(AXI_ID_W);
    localparam int RCH_W  = rch_width(AXI_DATA_W, AXI_ID_W);
    localparam int FIFO_A = fifo_addr_w(SLV_OSTDREQ_NUM);

    logic [BCH_W-1:0] bch;
    logic [RCH_W-1:0] rch;
    logic             b_full;
    logic             b_empty;
    logic             r_full;
    logic             r_empty;

    // Pack slave fields, id in the low bits
    assign bch = {i_bresp, i_bid};
    assign rch = {i_rdata, i_rresp, i_rid};

    //////////////////////////////
    // Response buffers
    //////////////////////////////

    axicb_scfifo #(.ADDR_WIDTH(FIFO_A), .DATA_WIDTH(BCH_W)) b_fifo (
        .i_aclk(i_aclk), .i_reset(i_reset),
        .i_push(i_bvalid), .i_data(bch), .o_full(b_full),
        .i_pull(i_bready), .o_data(o_bch), .o_empty(b_empty)
    );

    axicb_scfifo #(.ADDR_WIDTH(FIFO_A), .DATA_WIDTH(RCH_W)) r_fifo (
        .i_aclk(i_aclk), .i_reset(i_reset),
        .i_push(i_rvalid), .i_data(rch), .o_full(r_full),
        .i_pull(i_rready), .o_data(o_rch), .o_empty(r_empty)
    );

    assign o_bready = !b_full;
    assign o_bvalid = !b_empty;
    assign o_rready = !r_full;
    assign o_rvalid = !r_empty;

    // B response held with its payload until the switch takes it
    a_b_hold: assert property (
        @(posedge i_aclk) disable iff (i_reset)
        (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bch))
    );

endmodule

//--- src/axicb_mst_if.sv
//////////////////////////////
// AXI4-lite master port stage, one instance per external slave
// Buffers all five channels between the switching logic and the slave
//////////////////////////////

module axicb_mst_if #(
    parameter int                    AXI_ADDR_W      = 16,
    parameter int                    AXI_ID_W        = 4,
    parameter int                    AXI_DATA_W      = 32,
    parameter logic [AXI_ADDR_W-1:0] BASE_ADDR       = 16'h4000,
    parameter int                    KEEP_BASE_ADDR  = 0,
    parameter int                    SLV_OSTDREQ_NUM = 4
) (
    input  logic                                                  i_aclk,
    input  logic                                                  i_reset,

    //////////////////////////////
    // Switching logic side
    //////////////////////////////

    input  logic                                                  i_awvalid,
    output logic                                                  o_awready,
    input  logic [axicb_pkg::awch_width(AXI_ADDR_W, AXI_ID_W)-1:0] i_awch,
    input  logic                                                  i_wvalid,
    output logic                                                  o_wready,
    input  logic [axicb_pkg::wch_width(AXI_DATA_W)-1:0]           i_wch,
    input  logic                                                  i_arvalid,
    output logic                                                  o_arready,
    input  logic [axicb_pkg::awch_width(AXI_ADDR_W, AXI_ID_W)-1:0] i_arch,
    output logic                                                  o_bvalid,
    input  logic                                                  i_bready,
    output logic [axicb_pkg::bch_width(AXI_ID_W)-1:0]             o_bch,
    output logic                                                  o_rvalid,
    input  logic                                                  i_rready,
    output logic [axicb_pkg::rch_width(AXI_DATA_W, AXI_ID_W)-1:0]  o_rch,

    //////////////////////////////
    // External slave side
    //////////////////////////////

    output logic                                                  o_awvalid,
    input  logic                                                  i_awready,
    output logic [AXI_ADDR_W-1:0]                                 o_awaddr,
    output logic [axicb_pkg::PROT_W-1:0]                          o_awprot,
    output logic [AXI_ID_W-1:0]                                   o_awid,
    output logic                                                  o_wvalid,
    input  logic                                                  i_wready,
    output logic [AXI_DATA_W-1:0]                                 o_wdata,
    output logic [AXI_DATA_W/8-1:0]                               o_wstrb,
    input  logic                                                  i_bvalid,
    output logic                                                  o_bready,
    input  logic [AXI_ID_W-1:0]                                   i_bid,
    input  logic [axicb_pkg::RESP_W-1:0]                          i_bresp,
    output logic                                                  o_arvalid,
    input  logic                                                  i_arready,
    output logic [AXI_ADDR_W-1:0]                                 o_araddr,
    output logic [axicb_pkg::PROT_W-1:0]                          o_arprot,
    output logic [AXI_ID_W-1:0]                                   o_arid,
    input  logic                                                  i_rvalid,
    output logic                                                  o_rready,
    input  logic [AXI_ID_W-1:0]                                   i_rid,
    input  logic [axicb_pkg::RESP_W-1:0]                          i_rresp,
    input  logic [AXI_DATA_W-1:0]                                 i_rdata
);

    // Requests toward the slave
    axicb_req_path #(
        .AXI_ADDR_W      (AXI_ADDR_W),
        .AXI_ID_W        (AXI_ID_W),
        .AXI_DATA_W      (AXI_DATA_W),
        .BASE_ADDR       (BASE_ADDR),
        .KEEP_BASE_ADDR  (KEEP_BASE_ADDR),
        .SLV_OSTDREQ_NUM (SLV_OSTDREQ_NUM)
    ) u_req_path (
        .i_aclk    (i_aclk),    .i_reset   (i_reset),
        .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awch (i_awch),
        .i_wvalid  (i_wvalid),  .o_wready  (o_wready),  .i_wch  (i_wch),
        .i_arvalid (i_arvalid), .o_arready (o_arready), .i_arch (i_arch),
        .o_awvalid (o_awvalid), .i_awready (i_awready), .o_awaddr (o_awaddr),
        .o_awprot  (o_awprot),  .o_awid    (o_awid),
        .o_wvalid  (o_wvalid),  .i_wready  (i_wready),
        .o_wdata   (o_wdata),   .o_wstrb   (o_wstrb),
        .o_arvalid (o_arvalid), .i_arready (i_arready), .o_araddr (o_araddr),
        .o_arprot  (o_arprot),  .o_arid    (o_arid)
    );

    // Responses back to the switching logic
    axicb_rsp_path #(
        .AXI_ID_W        (AXI_ID_W),
        .AXI_DATA_W      (AXI_DATA_W),
        .SLV_OSTDREQ_NUM (SLV_OSTDREQ_NUM)
    ) u_rsp_path (
        .i_aclk   (i_aclk),   .i_reset  (i_reset),
        .i_bvalid (i_bvalid), .o_bready (o_bready),
        .i_bid    (i_bid),    .i_bresp  (i_bresp),
        .i_rvalid (i_rvalid), .o_rready (o_rready),
        .i_rid    (i_rid),    .i_rresp  (i_rresp), .i_rdata (i_rdata),
        .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bch (o_bch),
        .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rch (o_rch)
    );

endmodule

//--- testbench/axicb_mst_if_tb.sv
//////////////////////////////
// Directed testbench for the AXI4-lite master port stage
// Runs reset, field split, response packing and back-pressure tests
//////////////////////////////

module axicb_mst_if_tb;

    import axicb_pkg::*;

    localparam int AXI_ADDR_W = 16;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AWCH_W     = awch_width(AXI_ADDR_W, AXI_ID_W);
    localparam int WCH_W      = wch_width(AXI_DATA_W);
    localparam int BCH_W      = bch_width(AXI_ID_W);
    localparam int RCH_W      = rch_width(AXI_DATA_W, AXI_ID_W);
    localparam int FIFO_DEPTH = 4;

    localparam logic [AXI_ADDR_W-1:0] SLV_BASE = 16'h4000;

    localparam int CLK_PERIOD      = 8;
    localparam int WAIT_LIMIT      = 16;
    localparam int TEST_CYCLES     = 60;
    localparam int WATCHDOG_MARGIN = 200;

    // Output valid selectors
    localparam int CH_AW = 0;
    localparam int CH_B  = 1;

    logic                    i_aclk;
    logic                    i_reset;
    logic                    i_awvalid;
    logic                    o_awready;
    logic [AWCH_W-1:0]       i_awch;
    logic                    i_wvalid;
    logic                    o_wready;
    logic [WCH_W-1:0]        i_wch;
    logic                    i_arvalid;
    logic                    o_arready;
    logic [AWCH_W-1:0]       i_arch;
    logic                    o_bvalid;
    logic                    i_bready;
    logic [BCH_W-1:0]        o_bch;
    logic                    o_rvalid;
    logic                    i_rready;
    logic [RCH_W-1:0]        o_rch;
    logic                    o_awvalid;
    logic                    i_awready;
    logic [AXI_ADDR_W-1:0]   o_awaddr;
    logic [PROT_W-1:0]       o_awprot;
    logic [AXI_ID_W-1:0]     o_awid;
    logic                    o_wvalid;
    logic                    i_wready;
    logic [AXI_DATA_W-1:0]   o_wdata;
    logic [AXI_DATA_W/8-1:0] o_wstrb;
    logic                    i_bvalid;
    logic                    o_bready;
    logic [AXI_ID_W-1:0]     i_bid;
    logic [RESP_W-1:0]       i_bresp;
    logic                    o_arvalid;
    logic                    i_arready;
    logic [AXI_ADDR_W-1:0]   o_araddr;
    logic [PROT_W-1:0]       o_arprot;
    logic [AXI_ID_W-1:0]     o_arid;
    logic                    i_rvalid;
    logic                    o_rready;
    logic [AXI_ID_W-1:0]     i_rid;
    logic [RESP_W-1:0]       i_rresp;
    logic [AXI_DATA_W-1:0]   i_rdata;

    integer seed;
    int     checks;
    int     errors;

    axicb_mst_if dut0 (.*);

    always #(CLK_PERIOD / 2) i_aclk = ~i_aclk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Step to just after the next rising edge
    task automatic next_cycle();
        @(posedge i_aclk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic logic out_valid(input int ch);
        case (ch)
            CH_AW:   return o_awvalid;
            default: return o_bvalid;
        endcase
    endfunction

    task automatic wait_valid(input int ch, input string name);
        int cycles;
        cycles = 0;
        while (!out_valid(ch) && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        checks++;
        assert (out_valid(ch)) else begin
            errors++;
            $display("Timed out waiting for %s to rise", name);
        end
    endtask

    // Address word {prot, id, addr} inside the slave window
    function automatic logic [AWCH_W-1:0] random_addr_word();
        logic [PROT_W-1:0]     prot;
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] offset;
        prot   = PROT_W'($random(seed));
        id     = AXI_ID_W'($random(seed));
        offset = AXI_ADDR_W'($random(seed)) & 16'h7fff;
        return {prot, id, SLV_BASE + offset};
    endfunction

    task automatic init_inputs();
        i_aclk    = 1'b0;
        i_reset   = 1'b1;
        i_awvalid = 1'b0;
        i_awch    = '0;
        i_wvalid  = 1'b0;
        i_wch     = '0;
        i_arvalid = 1'b0;
        i_arch    = '0;
        i_bready  = 1'b0;
        i_rready  = 1'b0;
        i_awready = 1'b0;
        i_wready  = 1'b0;
        i_bvalid  = 1'b0;
        i_bid     = '0;
        i_bresp   = '0;
        i_arready = 1'b0;
        i_rvalid  = 1'b0;
        i_rid     = '0;
        i_rresp   = '0;
        i_rdata   = '0;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_state_test();
        check_value("o_awvalid", o_awvalid, 1'b0);
        check_value("o_wvalid", o_wvalid, 1'b0);
        check_value("o_arvalid", o_arvalid, 1'b0);
        check_value("o_bvalid", o_bvalid, 1'b0);
        check_value("o_rvalid", o_rvalid, 1'b0);
        check_value("o_awready", o_awready, 1'b1);
        check_value("o_wready", o_wready, 1'b1);
        check_value("o_arready", o_arready, 1'b1);
        check_value("o_bready", o_bready, 1'b1);
        check_value("o_rready", o_rready, 1'b1);
    endtask

    task automatic aw_w_test();
        logic [AWCH_W-1:0]       word;
        logic [AXI_DATA_W-1:0]   data;
        logic [AXI_DATA_W/8-1:0] strb;
        word = random_addr_word();
        data = AXI_DATA_W'($random(seed));
        strb = (AXI_DATA_W/8)'($random(seed));
        i_awch    = word;
        i_awvalid = 1'b1;
        i_wch     = {strb, data};
        i_wvalid  = 1'b1;
        next_cycle();
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        // One cycle latency from the accepting edge
        check_value("o_awvalid", o_awvalid, 1'b1);
        check_value("o_awprot", o_awprot, word[AWCH_W-1 -: PROT_W]);
        check_value("o_awid", o_awid, word[AXI_ADDR_W +: AXI_ID_W]);
        check_value("o_awaddr", o_awaddr, word[AXI_ADDR_W-1:0] - SLV_BASE);
        check_value("o_wvalid", o_wvalid, 1'b1);
        check_value("o_wdata", o_wdata, data);
        check_value("o_wstrb", o_wstrb, strb);
        i_awready = 1'b1;
        i_wready  = 1'b1;
        next_cycle();
        i_awready = 1'b0;
        i_wready  = 1'b0;
        check_value("o_awvalid", o_awvalid, 1'b0);
        check_value("o_wvalid", o_wvalid, 1'b0);
    endtask

    task automatic ar_r_test();
        logic [AWCH_W-1:0]     word;
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        word = random_addr_word();
        i_arch    = word;
        i_arvalid = 1'b1;
        next_cycle();
        i_arvalid = 1'b0;
        check_value("o_arvalid", o_arvalid, 1'b1);
        check_value("o_arprot", o_arprot, word[AWCH_W-1 -: PROT_W]);
        check_value("o_arid", o_arid, word[AXI_ADDR_W +: AXI_ID_W]);
        check_value("o_araddr", o_araddr, word[AXI_ADDR_W-1:0] - SLV_BASE);
        i_arready = 1'b1;
        next_cycle();
        i_arready = 1'b0;
        check_value("o_arvalid", o_arvalid, 1'b0);

        // Slave answers with one read beat
        id       = word[AXI_ADDR_W +: AXI_ID_W];
        data     = AXI_DATA_W'($random(seed));
        i_rid    = id;
        i_rresp  = RESP_SLVERR;
        i_rdata  = data;
        i_rvalid = 1'b1;
        next_cycle();
        i_rvalid = 1'b0;
        check_value("o_rvalid", o_rvalid, 1'b1);
        check_value("o_rch", o_rch, {data, RESP_SLVERR, id});
        i_rready = 1'b1;
        next_cycle();
        i_rready = 1'b0;
        check_value("o_rvalid", o_rvalid, 1'b0);
    endtask

    task automatic aw_backpressure_test();
        logic [AWCH_W-1:0] word;
        logic [AWCH_W-1:0] sent[$];
        int                accepted;
        accepted  = 0;
        i_awready = 1'b0;
        while (o_awready && accepted < 2 * FIFO_DEPTH) begin
            word      = random_addr_word();
            i_awch    = word;
            i_awvalid = 1'b1;
            next_cycle();
            sent.push_back(word);
            accepted++;
        end
        i_awvalid = 1'b0;
        check_value("accepted AW words", accepted, FIFO_DEPTH);
        check_value("o_awready", o_awready, 1'b0);

        // Drain in order
        i_awready = 1'b1;
        while (sent.size() > 0) begin
            word = sent.pop_front();
            wait_valid(CH_AW, "o_awvalid");
            check_value("o_awid", o_awid, word[AXI_ADDR_W +: AXI_ID_W]);
            check_value("o_awprot", o_awprot, word[AWCH_W-1 -: PROT_W]);
            check_value("o_awaddr", o_awaddr, word[AXI_ADDR_W-1:0] - SLV_BASE);
            next_cycle();
        end
        i_awready = 1'b0;
        check_value("o_awvalid", o_awvalid, 1'b0);
    endtask

    task automatic b_backpressure_test();
        logic [BCH_W-1:0]    expected[$];
        logic [BCH_W-1:0]    pair;
        logic [AXI_ID_W-1:0] id;
        logic [RESP_W-1:0]   resp;
        i_bready = 1'b0;
        for (int n = 0; n < 3; n++) begin
            check_value("o_bready", o_bready, 1'b1);
            id       = AXI_ID_W'($random(seed));
            resp     = (n % 2 == 0) ? RESP_OKAY : RESP_SLVERR;
            i_bid    = id;
            i_bresp  = resp;
            i_bvalid = 1'b1;
            next_cycle();
            expected.push_back({resp, id});
        end
        i_bvalid = 1'b0;
        check_value("o_bvalid", o_bvalid, 1'b1);
        check_value("o_bready", o_bready, 1'b1);

        i_bready = 1'b1;
        while (expected.size() > 0) begin
            pair = expected.pop_front();
            wait_valid(CH_B, "o_bvalid");
            check_value("o_bch", o_bch, pair);
            next_cycle();
        end
        i_bready = 1'b0;
        check_value("o_bvalid", o_bvalid, 1'b0);
    endtask

    //////////////////////////////
    // Sequence and watchdog
    //////////////////////////////

    initial begin
        seed   = 8;
        checks = 0;
        errors = 0;
        init_inputs();
        repeat (3) next_cycle();
        i_reset = 1'b0;
        reset_state_test();
        aw_w_test();
        ar_r_test();
        aw_backpressure_test();
        b_backpressure_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("Watchdog expired before the tests finished");
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- filelist.f
src/axicb_pkg.sv
src/axicb_scfifo.sv
src/axicb_req_path.sv
src/axicb_rsp_path.sv
src/axicb_mst_if.sv
testbench/axicb_mst_if_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := axicb_mst_if_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
